//--- Makefile
# Verilator simulation of the complex-integer back end

VERILATOR ?= verilator
TOP       ?= complexIntTb
DUT       ?= complexIntCore
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
RTL       ?= verilog/cplxPkg.sv verilog/physRegFile.sv verilog/mulExecPipe.sv \
             verilog/regWriteStage.sv verilog/complexIntCore.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# The run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -Iverilog $(RTL) --top-module $(DUT)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

//--- tb/complexIntTb.sv
//--------------------------------------------------------------------------
// Testbench for the complex-integer back end
// Table-driven loads, multiplies, stalls, flushes and clears, checked
// against a register mirror and an in-order completion queue
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "cplxParams.svh"

module complexIntTb;

    localparam int          ClkPeriod  = 8;
    localparam int          NumRows    = 57;
    localparam int          DrainLimit = `CPLX_MUL_STAGES + 4;
    localparam logic [31:0] LfsrSeed   = 32'hf07e_05f6;

    typedef enum logic [2:0] {
        kindIdle,
        kindLoad,
        kindIssue,
        kindStall,
        kindClear
    } kindT;

    typedef struct packed {
        kindT            kind;
        cplxPkg::regNumT srcA;
        cplxPkg::regNumT srcB;
        cplxPkg::regNumT dst;
        logic            writeReg;
        cplxPkg::alPtrT  ptr;
        logic            rnd;
        cplxPkg::dataT   data;
        logic            rec;
        logic            all;
        cplxPkg::alPtrT  head;
        cplxPkg::alPtrT  tail;
        logic            completes;
    } rowT;

    // One expected completion, in issue order
    typedef struct packed {
        cplxPkg::regNumT dst;
        logic            writeReg;
        cplxPkg::alPtrT  ptr;
        cplxPkg::dataT   data;
        int              issueCycle;
        int              stallsAtIssue;
    } expT;

    logic            ctrl;
    logic            arstN;
    logic            issueValid;
    cplxPkg::regNumT issueSrcA;
    cplxPkg::regNumT issueSrcB;
    cplxPkg::regNumT issueDst;
    logic            issueWriteReg;
    cplxPkg::alPtrT  issueAlPtr;
    logic            loadWe;
    cplxPkg::regNumT loadReg;
    cplxPkg::dataT   loadData;
    logic            stall;
    logic            clear;
    logic            toRecovery;
    logic            flushAll;
    cplxPkg::alPtrT  flushHead;
    cplxPkg::alPtrT  flushTail;
    logic            wbValid;
    cplxPkg::regNumT wbReg;
    cplxPkg::dataT   wbData;
    logic            alWrite;
    cplxPkg::alPtrT  alPtr;

    rowT             tbl [NumRows];
    int              rowCount = 0;
    logic            curRec;
    logic            curAll;
    cplxPkg::alPtrT  curHead;
    cplxPkg::alPtrT  curTail;
    cplxPkg::dataT   model [`CPLX_PHYS_REGS] = '{default: '0};
    expT             expQ [$];
    logic [31:0]     lfsrState;
    int              cycleNum = 0;
    int              stallCount = 0;

    complexIntCore i_complexIntCore (
        .ctrl          (ctrl),
        .arstN         (arstN),
        .issueValid    (issueValid),
        .issueSrcA     (issueSrcA),
        .issueSrcB     (issueSrcB),
        .issueDst      (issueDst),
        .issueWriteReg (issueWriteReg),
        .issueAlPtr    (issueAlPtr),
        .loadWe        (loadWe),
        .loadReg       (loadReg),
        .loadData      (loadData),
        .stall         (stall),
        .clear         (clear),
        .toRecovery    (toRecovery),
        .flushAll      (flushAll),
        .flushHead     (flushHead),
        .flushTail     (flushTail),
        .wbValid       (wbValid),
        .wbReg         (wbReg),
        .wbData        (wbData),
        .alWrite       (alWrite),
        .alPtr         (alPtr)
    );

    initial begin
        ctrl = 1'b0;
        forever #(ClkPeriod / 2) ctrl = ~ctrl;
    end

    initial begin
        #(NumRows * (`CPLX_MUL_STAGES + 6) * ClkPeriod);
        abortRun("Simulation timed out before the stimulus table drained");
    end

    task automatic reportMismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compareData(input cplxPkg::dataT got, input cplxPkg::dataT exp,
                               input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compareReg(input cplxPkg::regNumT got, input cplxPkg::regNumT exp,
                              input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic comparePtr(input cplxPkg::alPtrT got, input cplxPkg::alPtrT exp,
                              input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic cplxPkg::dataT randWord();
        cplxPkg::dataT w;
        w = '0;
        for (int i = 0; i < `CPLX_DATA_WIDTH; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[`CPLX_DATA_WIDTH-2:0], lfsrState[0]};
        end
        return w;
    endfunction

    task automatic setRecovery(input logic rec, input logic all,
                               input cplxPkg::alPtrT head, input cplxPkg::alPtrT tail);
        curRec  = rec;
        curAll  = all;
        curHead = head;
        curTail = tail;
    endtask

    task automatic pushRow(input rowT r);
        r.rec  = curRec;
        r.all  = curAll;
        r.head = curHead;
        r.tail = curTail;
        tbl[rowCount] = r;
        rowCount++;
    endtask

    task automatic loadRow(input cplxPkg::regNumT dst, input logic rnd,
                           input cplxPkg::dataT data);
        rowT r;
        r      = '0;
        r.kind = kindLoad;
        r.dst  = dst;
        r.rnd  = rnd;
        r.data = data;
        pushRow(r);
    endtask

    task automatic issueRow(input cplxPkg::regNumT a, input cplxPkg::regNumT b,
                            input cplxPkg::regNumT dst, input logic wr,
                            input cplxPkg::alPtrT ptr, input logic completes);
        rowT r;
        r           = '0;
        r.kind      = kindIssue;
        r.srcA      = a;
        r.srcB      = b;
        r.dst       = dst;
        r.writeReg  = wr;
        r.ptr       = ptr;
        r.completes = completes;
        pushRow(r);
    endtask

    task automatic quietRows(input kindT kind, input int count);
        rowT r;
        r      = '0;
        r.kind = kind;
        repeat (count) pushRow(r);
    endtask

    // Completion flags follow the flush, stall and clear rules
    task automatic buildTable();
        setRecovery(1'b0, 1'b0, 6'd0, 6'd0);
        loadRow(5'd1, 1'b1, 32'h0);
        loadRow(5'd2, 1'b1, 32'h0);
        loadRow(5'd3, 1'b0, 32'hffff_ffff);
        loadRow(5'd9, 1'b1, 32'h0);
        loadRow(5'd31, 1'b0, 32'h1);
        // Back to back, the last one without a register write
        issueRow(5'd1, 5'd2, 5'd4, 1'b1, 6'd1, 1'b1);
        issueRow(5'd3, 5'd3, 5'd5, 1'b1, 6'd2, 1'b1);
        issueRow(5'd1, 5'd3, 5'd6, 1'b1, 6'd3, 1'b1);
        issueRow(5'd1, 5'd2, 5'd9, 1'b0, 6'd4, 1'b1);
        quietRows(kindIdle, 2);
        issueRow(5'd4, 5'd5, 5'd7, 1'b1, 6'd5, 1'b1);
        quietRows(kindIdle, 1);
        issueRow(5'd9, 5'd31, 5'd10, 1'b1, 6'd6, 1'b1);
        issueRow(5'd6, 5'd2, 5'd11, 1'b1, 6'd7, 1'b1);
        // Stall with work in flight
        issueRow(5'd1, 5'd1, 5'd12, 1'b1, 6'd8, 1'b1);
        issueRow(5'd2, 5'd3, 5'd13, 1'b1, 6'd9, 1'b1);
        issueRow(5'd7, 5'd31, 5'd14, 1'b1, 6'd10, 1'b1);
        quietRows(kindStall, 4);
        quietRows(kindIdle, 5);
        // Wrapping range 60 up to 2, tail excluded
        setRecovery(1'b1, 1'b0, 6'd60, 6'd2);
        issueRow(5'd1, 5'd2, 5'd15, 1'b1, 6'd62, 1'b0);
        issueRow(5'd1, 5'd2, 5'd16, 1'b1, 6'd2, 1'b1);
        issueRow(5'd2, 5'd2, 5'd17, 1'b1, 6'd1, 1'b0);
        issueRow(5'd3, 5'd1, 5'd18, 1'b1, 6'd59, 1'b1);
        issueRow(5'd1, 5'd2, 5'd19, 1'b1, 6'd60, 1'b0);
        issueRow(5'd2, 5'd3, 5'd20, 1'b1, 6'd0, 1'b0);
        issueRow(5'd9, 5'd9, 5'd21, 1'b1, 6'd30, 1'b1);
        quietRows(kindIdle, 4);
        setRecovery(1'b1, 1'b1, 6'd10, 6'd12);
        issueRow(5'd1, 5'd2, 5'd22, 1'b1, 6'd40, 1'b0);
        issueRow(5'd2, 5'd9, 5'd23, 1'b1, 6'd11, 1'b0);
        quietRows(kindIdle, 4);
        setRecovery(1'b0, 1'b0, 6'd0, 6'd0);
        // Clear while these three are in flight
        issueRow(5'd1, 5'd3, 5'd4, 1'b1, 6'd14, 1'b0);
        issueRow(5'd2, 5'd2, 5'd5, 1'b1, 6'd15, 1'b0);
        issueRow(5'd9, 5'd3, 5'd6, 1'b1, 6'd16, 1'b0);
        quietRows(kindIdle, 1);
        quietRows(kindClear, 1);
        // Read back registers that must have kept their values
        issueRow(5'd4, 5'd31, 5'd24, 1'b1, 6'd17, 1'b1);
        issueRow(5'd5, 5'd6, 5'd25, 1'b1, 6'd18, 1'b1);
        issueRow(5'd18, 5'd16, 5'd26, 1'b1, 6'd19, 1'b1);
        issueRow(5'd15, 5'd31, 5'd27, 1'b1, 6'd20, 1'b1);
        quietRows(kindIdle, 4);
        if (rowCount != NumRows) begin
            abortRun("Stimulus table row count does not match its declared size");
        end
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge ctrl) begin
        expT e;
        int  due;
        if (arstN === 1'b1) begin
            if ($isunknown(alWrite) || wbValid !== alWrite) begin
                abortRun("Completion strobe is unknown or disagrees with writeback valid");
            end
            if (loadWe) begin
                model[loadReg] = loadData;
            end
            if (alWrite) begin
                if (expQ.size() == 0) begin
                    abortRun("A completion appeared while none was expected");
                end else begin
                    e = expQ.pop_front();
                    comparePtr(alPtr, e.ptr, "completion pointer");
                    compareReg(wbReg, e.dst, "writeback register");
                    compareData(wbData, e.data, "writeback data");
                    // Each stalled cycle adds one cycle of latency
                    due = e.issueCycle + `CPLX_MUL_STAGES + 1 + stallCount - e.stallsAtIssue;
                    if (cycleNum != due) begin
                        reportMismatch($sformatf("pointer %0d completed in cycle %0d, not %0d",
                                                 e.ptr, cycleNum, due));
                    end
                    if (e.writeReg) begin
                        model[e.dst] = e.data;
                    end
                end
            end
        end
        if (stall) begin
            stallCount++;
        end
        cycleNum++;
    end

    initial begin
        expT e;
        rowT r;
        int  w;
        lfsrState     = LfsrSeed;
        arstN         = 1'b0;
        issueValid    = 1'b0;
        issueSrcA     = '0;
        issueSrcB     = '0;
        issueDst      = '0;
        issueWriteReg = 1'b0;
        issueAlPtr    = '0;
        loadWe        = 1'b0;
        loadReg       = '0;
        loadData      = '0;
        stall         = 1'b0;
        clear         = 1'b0;
        toRecovery    = 1'b0;
        flushAll      = 1'b0;
        flushHead     = '0;
        flushTail     = '0;
        buildTable();
        repeat (4) @(posedge ctrl);
        arstN <= 1'b1;
        for (int i = 0; i < NumRows; i++) begin
            @(posedge ctrl);
            r = tbl[i];
            issueValid <= 1'b0;
            loadWe     <= 1'b0;
            stall      <= 1'b0;
            clear      <= 1'b0;
            toRecovery <= r.rec;
            flushAll   <= r.all;
            flushHead  <= r.head;
            flushTail  <= r.tail;
            case (r.kind)
                kindLoad: begin
                    loadWe   <= 1'b1;
                    loadReg  <= r.dst;
                    loadData <= r.rnd ? randWord() : r.data;
                end
                kindIssue: begin
                    issueValid    <= 1'b1;
                    issueSrcA     <= r.srcA;
                    issueSrcB     <= r.srcB;
                    issueDst      <= r.dst;
                    issueWriteReg <= r.writeReg;
                    issueAlPtr    <= r.ptr;
                    if (r.completes) begin
                        e.dst           = r.dst;
                        e.writeReg      = r.writeReg;
                        e.ptr           = r.ptr;
                        // Low half of the product of the current register values
                        e.data          = model[r.srcA] * model[r.srcB];
                        e.issueCycle    = cycleNum;
                        e.stallsAtIssue = stallCount;
                        expQ.push_back(e);
                    end
                end
                kindStall: stall <= 1'b1;
                kindClear: clear <= 1'b1;
                default: begin
                end
            endcase
        end
        for (w = 0; w < DrainLimit && expQ.size() != 0; w++) begin
            @(posedge ctrl);
        end
        if (expQ.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun($sformatf("%0d expected completions never arrived", expQ.size()));
        end
    end

endmodule

//--- verilog/complexIntCore.sv
//--------------------------------------------------------------------------
// Complex-integer back end
// Register file read, multiply pipeline and register-write stage
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module complexIntCore (
    input  logic            ctrl,
    input  logic            arstN,

    // Issue group
    input  logic            issueValid,
    input  cplxPkg::regNumT issueSrcA,
    input  cplxPkg::regNumT issueSrcB,
    input  cplxPkg::regNumT issueDst,
    input  logic            issueWriteReg,
    input  cplxPkg::alPtrT  issueAlPtr,

    // Load unit write port
    input  logic            loadWe,
    input  cplxPkg::regNumT loadReg,
    input  cplxPkg::dataT   loadData,

    // Pipeline control
    input  logic            stall,
    input  logic            clear,

    // Recovery
    input  logic            toRecovery,
    input  logic            flushAll,
    input  cplxPkg::alPtrT  flushHead,
    input  cplxPkg::alPtrT  flushTail,

    // Writeback bus and completion
    output logic            wbValid,
    output cplxPkg::regNumT wbReg,
    output cplxPkg::dataT   wbData,
    output logic            alWrite,
    output cplxPkg::alPtrT  alPtr
);

    cplxPkg::dataT   rdDataA;
    cplxPkg::dataT   rdDataB;

    logic            exValid;
    cplxPkg::regNumT exDst;
    logic            exWriteReg;
    cplxPkg::alPtrT  exAlPtr;
    cplxPkg::dataT   exResult;

    logic            wbWe;

    physRegFile i_physRegFile (
        .ctrl    (ctrl),
        .arstN   (arstN),
        .rdRegA  (issueSrcA),
        .rdRegB  (issueSrcB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrWeA   (wbWe),
        .wrRegA  (wbReg),
        .wrDataA (wbData),
        .wrWeB   (loadWe),
        .wrRegB  (loadReg),
        .wrDataB (loadData)
    );

    mulExecPipe i_mulExecPipe (
        .ctrl        (ctrl),
        .arstN       (arstN),
        .stall       (stall),
        .clear       (clear),
        .inValid     (issueValid),
        .inDst       (issueDst),
        .inWriteReg  (issueWriteReg),
        .inAlPtr     (issueAlPtr),
        .opA         (rdDataA),
        .opB         (rdDataB),
        .outValid    (exValid),
        .outDst      (exDst),
        .outWriteReg (exWriteReg),
        .outAlPtr    (exAlPtr),
        .outResult   (exResult)
    );

    regWriteStage i_regWriteStage (
        .ctrl       (ctrl),
        .arstN      (arstN),
        .stall      (stall),
        .clear      (clear),
        .toRecovery (toRecovery),
        .flushAll   (flushAll),
        .flushHead  (flushHead),
        .flushTail  (flushTail),
        .inValid    (exValid),
        .inDst      (exDst),
        .inWriteReg (exWriteReg),
        .inAlPtr    (exAlPtr),
        .inResult   (exResult),
        .regWe      (wbWe),
        .regNum     (wbReg),
        .regData    (wbData),
        .alWrite    (alWrite),
        .alPtr      (alPtr),
        .wbValid    (wbValid)
    );

endmodule

//--- verilog/cplxParams.svh
//--------------------------------------------------------------------------
// Complex-integer back end widths and sizes
// Data width, register file size, active-list pointer and multiply depth
//--------------------------------------------------------------------------
`ifndef CPLX_PARAMS_SVH
`define CPLX_PARAMS_SVH

// Data word
`define CPLX_DATA_WIDTH 32

// Physical register file
`define CPLX_PHYS_REGS 32
`define CPLX_REG_NUM_WIDTH 5

// Pointer into a 64-entry active list
`define CPLX_AL_PTR_WIDTH 6

// Registered stages in the multiplier
`define CPLX_MUL_STAGES 3

`endif

//--- verilog/cplxPkg.sv
//--------------------------------------------------------------------------
// Complex-integer back end types
// Vector types shared by the register file, multiplier and write stage
//--------------------------------------------------------------------------
`include "cplxParams.svh"

package cplxPkg;

    // One register value
    typedef logic [`CPLX_DATA_WIDTH-1:0] dataT;

    // Physical register number
    typedef logic [`CPLX_REG_NUM_WIDTH-1:0] regNumT;

    // Active-list entry pointer, wraps modulo the list size
    typedef logic [`CPLX_AL_PTR_WIDTH-1:0] alPtrT;

endpackage

//--- verilog/mulExecPipe.sv
//--------------------------------------------------------------------------
// Multiply execution pipeline
// Forms the product in the first stage and carries it with its micro-op
// tags through a fixed number of registered stages
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "cplxParams.svh"

module mulExecPipe (
    input  logic            ctrl,
    input  logic            arstN,

    // Pipeline control
    input  logic            stall,
    input  logic            clear,

    // Micro-op tags from issue
    input  logic            inValid,
    input  cplxPkg::regNumT inDst,
    input  logic            inWriteReg,
    input  cplxPkg::alPtrT  inAlPtr,

    // Operands from the register file
    input  cplxPkg::dataT   opA,
    input  cplxPkg::dataT   opB,

    // Last stage towards the register-write stage
    output logic            outValid,
    output cplxPkg::regNumT outDst,
    output logic            outWriteReg,
    output cplxPkg::alPtrT  outAlPtr,
    output cplxPkg::dataT   outResult
);

    localparam int Stages    = `CPLX_MUL_STAGES;
    localparam int ProdWidth = 2 * `CPLX_DATA_WIDTH;

    // Full-width product, operands extended by the context width
    logic [ProdWidth-1:0] product;

    logic                 stValid    [Stages];
    cplxPkg::regNumT      stDst      [Stages];
    logic                 stWriteReg [Stages];
    cplxPkg::alPtrT       stAlPtr    [Stages];
    logic [ProdWidth-1:0] stProduct  [Stages];

    assign product = opA * opB;

    // Valid bits, dropped by clear even during a stall
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Stages; i++) begin
                stValid[i] <= 1'b0;
            end
        end else if (clear) begin
            for (int i = 0; i < Stages; i++) begin
                stValid[i] <= 1'b0;
            end
        end else if (!stall) begin
            stValid[0] <= inValid;
            for (int i = 1; i < Stages; i++) begin
                stValid[i] <= stValid[i-1];
            end
        end
    end

    // Payload shifts along with the valid bits
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            stDst[0]      <= inDst;
            stWriteReg[0] <= inWriteReg;
            stAlPtr[0]    <= inAlPtr;
            stProduct[0]  <= product;
            for (int i = 1; i < Stages; i++) begin
                stDst[i]      <= stDst[i-1];
                stWriteReg[i] <= stWriteReg[i-1];
                stAlPtr[i]    <= stAlPtr[i-1];
                stProduct[i]  <= stProduct[i-1];
            end
        end
    end

    assign outValid    = stValid[Stages-1];
    assign outDst      = stDst[Stages-1];
    assign outWriteReg = stWriteReg[Stages-1];
    assign outAlPtr    = stAlPtr[Stages-1];
    // Only the low half is architecturally visible
    assign outResult   = stProduct[Stages-1][`CPLX_DATA_WIDTH-1:0];

endmodule

//--- verilog/physRegFile.sv
//--------------------------------------------------------------------------
// Physical register file
// Two combinational read ports, two write ports, writeback port has priority
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "cplxParams.svh"

module physRegFile (
    input  logic            ctrl,
    input  logic            arstN,

    // Operand reads for the multiplier
    input  cplxPkg::regNumT rdRegA,
    input  cplxPkg::regNumT rdRegB,
    output cplxPkg::dataT   rdDataA,
    output cplxPkg::dataT   rdDataB,

    // Port A from the register-write stage
    input  logic            wrWeA,
    input  cplxPkg::regNumT wrRegA,
    input  cplxPkg::dataT   wrDataA,

    // Port B from the load unit
    input  logic            wrWeB,
    input  cplxPkg::regNumT wrRegB,
    input  cplxPkg::dataT   wrDataB
);

    cplxPkg::dataT regs [`CPLX_PHYS_REGS];

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPLX_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Load port first
            if (wrWeB) begin
                regs[wrRegB] <= wrDataB;
            end
            // Writeback overrides a load to the same register
            if (wrWeA) begin
                regs[wrRegA] <= wrDataA;
            end
        end
    end

    // Reads see the value before this cycle's write
    assign rdDataA = regs[rdRegA];
    assign rdDataB = regs[rdRegB];

endmodule

//--- verilog/regWriteStage.sv
//--------------------------------------------------------------------------
// Register-write stage
// Pipeline register after the multiplier, selective flush test, register
// write, active-list completion and writeback broadcast
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module regWriteStage (
    input  logic            ctrl,
    input  logic            arstN,

    // Pipeline control
    input  logic            stall,
    input  logic            clear,

    // Recovery range from the recovery manager
    input  logic            toRecovery,
    input  logic            flushAll,
    input  cplxPkg::alPtrT  flushHead,
    input  cplxPkg::alPtrT  flushTail,

    // From the multiplier
    input  logic            inValid,
    input  cplxPkg::regNumT inDst,
    input  logic            inWriteReg,
    input  cplxPkg::alPtrT  inAlPtr,
    input  cplxPkg::dataT   inResult,

    // Register file write
    output logic            regWe,
    output cplxPkg::regNumT regNum,
    output cplxPkg::dataT   regData,

    // Completion and broadcast
    output logic            alWrite,
    output cplxPkg::alPtrT  alPtr,
    output logic            wbValid
);

    logic            rValid;
    cplxPkg::regNumT rDst;
    logic            rWriteReg;
    cplxPkg::alPtrT  rAlPtr;
    cplxPkg::dataT   rResult;

    logic            flush;
    logic            update;

    // Half-open range from head to tail, wrapping when tail is below head
    function automatic logic inFlushRange(cplxPkg::alPtrT ptr, cplxPkg::alPtrT head,
                                          cplxPkg::alPtrT tail);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            rValid <= 1'b0;
        end else if (clear) begin
            rValid <= 1'b0;
        end else if (!stall) begin
            rValid <= inValid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            rDst      <= inDst;
            rWriteReg <= inWriteReg;
            rAlPtr    <= inAlPtr;
            rResult   <= inResult;
        end
    end

    // Squashed entries retire silently
    assign flush  = toRecovery && (flushAll || inFlushRange(rAlPtr, flushHead, flushTail));
    assign update = rValid && !stall && !clear && !flush;

    assign regWe   = update && rWriteReg;
    assign regNum  = rDst;
    assign regData = rResult;

    assign alWrite = update;
    assign alPtr   = rAlPtr;
    assign wbValid = update;

endmodule

//--- vlog.f
+incdir+verilog
verilog/cplxPkg.sv
verilog/physRegFile.sv
verilog/mulExecPipe.sv
verilog/regWriteStage.sv
verilog/complexIntCore.sv
tb/complexIntTb.sv
